//--- filelist.f
src/TrapTypes.sv
src/TrapCsrFile.sv
src/PipelineController.sv
src/FetchPcUnit.sv
src/TrapRedirectTop.sv
tests/TrapRedirect_chk.sv
tests/TrapRedirectTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the trap redirect testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module TrapRedirectTb -o simTrapRedirect

output=$(./obj_dir/simTrapRedirect || true)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi

//--- src/FetchPcUnit.sv
// fetch pc register, loads redirect target on flush, holds on stall, else steps by 4
`timescale 1ns/1ps

module FetchPcUnit import TrapTypes::*; #(
    parameter vaddr_t ResetVector = 32'h0000_1000
) (
    input  logic      clk,
    input  logic      rstN,
    input  redirect_t redirect,             // flush and target from controller
    input  stall_t    stall,
    output vaddr_t    pc
);

    vaddr_t pcReg;
    vaddr_t pcNext;

    // flush has priority over stall
    always_comb begin
        if (redirect.flush) begin
            pcNext = redirect.nextPc;
        end
        else if (stall.ifStall) begin
            pcNext = pcReg;                 // hold
        end
        else begin
            pcNext = pcReg + 32'd4;         // sequential fetch
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg <= ResetVector;
        end
        else begin
            pcReg <= pcNext;
        end
    end

    assign pc = pcReg;

endmodule

//--- src/PipelineController.sv
// combinational redirect and stall control, picks the trap vector, return pc or flush target
`timescale 1ns/1ps

module PipelineController import TrapTypes::*; (
    input  trap_csr_view_t csrView,
    input  trap_req_t      trapReq,
    input  xret_req_t      xretReq,
    input  logic           flushReq,        // plain flush, e.g. branch mispredict
    input  vaddr_t         flushTarget,
    input  logic           exStallReq,      // execute back-pressure
    output redirect_t      redirect,
    output stall_t         stall
);

    csr_xtvec_t  xtvec;
    logic [29:0] vecBase;                   // word index of the vector
    vaddr_t      trapVector;
    vaddr_t      trapReturnPc;

    // tvec of the level the trap lands in
    always_comb begin
        unique case (csrView.nextPriv)
            Priv_Machine:    xtvec = csrView.mtvec;
            Priv_Supervisor: xtvec = csrView.stvec;
            Priv_User:       xtvec = csrView.utvec;
            default:         xtvec = '0;
        endcase
    end

    always_comb begin
        if (xtvec.MODE == XtvecModeVectored && trapReq.cause.isInterrupt) begin
            vecBase = xtvec.BASE + 30'(trapReq.cause.code); // per-cause slot
        end
        else begin
            vecBase = xtvec.BASE;           // exceptions always hit base
        end
        trapVector = {vecBase, 2'b00};
    end

    always_comb begin
        unique case (xretReq.priv)
            Priv_Machine:    trapReturnPc = csrView.mepc;
            Priv_Supervisor: trapReturnPc = csrView.sepc;
            Priv_User:       trapReturnPc = csrView.uepc;
            default:         trapReturnPc = '0;
        endcase
    end

    // trap beats xret beats plain flush
    always_comb begin
        if (trapReq.valid) begin
            redirect.nextPc = trapVector;
        end
        else if (xretReq.valid) begin
            redirect.nextPc = trapReturnPc;
        end
        else begin
            redirect.nextPc = flushTarget;
        end
        redirect.flush = flushReq || trapReq.valid || xretReq.valid;
    end

    // every stage freezes together on an execute stall
    always_comb begin
        stall.ifStall     = exStallReq;
        stall.idStall     = exStallReq;
        stall.rrStall     = exStallReq;
        stall.bypassStall = exStallReq;
    end

endmodule

//--- src/TrapCsrFile.sv
// trap CSRs and current privilege, tracks privilege across traps and returns for the controller
`timescale 1ns/1ps

module TrapCsrFile import TrapTypes::*; (
    input  logic           clk,
    input  logic           rstN,
    input  csr_write_t     csrWrite,        // external CSR write strobe
    input  trap_req_t      trapReq,         // trap from execute side
    input  xret_req_t      xretReq,         // mret / sret / uret
    output trap_csr_view_t csrView,
    output priv_t          curPriv
);

    csr_xtvec_t  mtvec;
    csr_xtvec_t  stvec;
    csr_xtvec_t  utvec;
    vaddr_t      mepc;
    vaddr_t      sepc;
    vaddr_t      uepc;
    logic [31:0] medeleg;                   // one bit per exception code
    priv_t       privReg;
    priv_t       nextPriv;
    logic        delegate;

    // exceptions only, and never out of machine mode
    assign delegate = !trapReq.cause.isInterrupt
                   && medeleg[trapReq.cause.code]
                   && (privReg != Priv_Machine);

    always_comb begin
        if (trapReq.valid) begin
            nextPriv = delegate ? Priv_Supervisor : Priv_Machine;
        end
        else if (xretReq.valid) begin
            nextPriv = xretReq.priv;        // level being returned from
        end
        else begin
            nextPriv = privReg;             // no change
        end
    end

    // CSR writes first, a trap's epc overrides the targeted xepc below
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mtvec   <= '0;
            stvec   <= '0;
            utvec   <= '0;
            mepc    <= '0;
            sepc    <= '0;
            uepc    <= '0;
            medeleg <= '0;
        end
        else begin
            if (csrWrite.valid) begin
                unique case (csrWrite.addr)
                    CsrMtvec:   mtvec   <= csrWrite.data;
                    CsrStvec:   stvec   <= csrWrite.data;
                    CsrUtvec:   utvec   <= csrWrite.data;
                    CsrMepc:    mepc    <= csrWrite.data;
                    CsrSepc:    sepc    <= csrWrite.data;
                    CsrUepc:    uepc    <= csrWrite.data;
                    CsrMedeleg: medeleg <= csrWrite.data;
                    default: ;                  // other CSRs live elsewhere
                endcase
            end
            if (trapReq.valid) begin
                unique case (nextPriv)
                    Priv_Machine:    mepc <= trapReq.epc;
                    Priv_Supervisor: sepc <= trapReq.epc;
                    Priv_User:       uepc <= trapReq.epc;
                    default: ;
                endcase
            end
        end
    end

    // privilege register, trap takes precedence over xret
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            privReg <= Priv_Machine;        // boot in machine mode
        end
        else if (trapReq.valid) begin
            privReg <= nextPriv;
        end
        else if (xretReq.valid) begin
            privReg <= Priv_User;           // no previous-priv stack here
        end
    end

    always_comb begin
        csrView.nextPriv = nextPriv;
        csrView.mtvec    = mtvec;
        csrView.stvec    = stvec;
        csrView.utvec    = utvec;
        csrView.mepc     = mepc;
        csrView.sepc     = sepc;
        csrView.uepc     = uepc;
    end

    assign curPriv = privReg;

endmodule

//--- src/TrapRedirectTop.sv
// top of the trap and redirect slice, wires CSR state to controller to fetch pc
`timescale 1ns/1ps

module TrapRedirectTop import TrapTypes::*; #(
    parameter vaddr_t ResetVector = 32'h0000_1000
) (
    input  logic       clk,
    input  logic       rstN,
    input  csr_write_t csrWrite,
    input  trap_req_t  trapReq,
    input  xret_req_t  xretReq,
    input  logic       flushReq,
    input  vaddr_t     flushTarget,
    input  logic       exStallReq,
    output vaddr_t     pc,
    output logic       flush,
    output stall_t     stall,
    output priv_t      curPriv
);

    trap_csr_view_t csrView;                // CSR state toward controller
    redirect_t      redirect;               // controller toward fetch

    TrapCsrFile u_TrapCsrFile (
        .clk      (clk),
        .rstN     (rstN),
        .csrWrite (csrWrite),
        .trapReq  (trapReq),
        .xretReq  (xretReq),
        .csrView  (csrView),
        .curPriv  (curPriv)
    );

    PipelineController u_PipelineController (
        .csrView     (csrView),
        .trapReq     (trapReq),
        .xretReq     (xretReq),
        .flushReq    (flushReq),
        .flushTarget (flushTarget),
        .exStallReq  (exStallReq),
        .redirect    (redirect),
        .stall       (stall)
    );

    FetchPcUnit #(
        .ResetVector (ResetVector)
    ) u_FetchPcUnit (
        .clk      (clk),
        .rstN     (rstN),
        .redirect (redirect),
        .stall    (stall),
        .pc       (pc)
    );

    assign flush = redirect.flush;          // exposed for the rest of the pipe

endmodule

//--- src/TrapTypes.sv
// shared privilege, CSR, trap and redirect types for the trap and redirect pipeline slice
package TrapTypes;

    typedef logic [31:0] vaddr_t;           // virtual address

    typedef enum logic [1:0] {
        Priv_User       = 2'b00,
        Priv_Supervisor = 2'b01,
        Priv_Machine    = 2'b11
    } priv_t;

    localparam logic [1:0] XtvecModeVectored = 2'b01; // vectored interrupt entry

    typedef struct packed {
        logic [29:0] BASE;                  // word-aligned vector base
        logic [1:0]  MODE;                  // 0 direct, 1 vectored
    } csr_xtvec_t;

    typedef struct packed {
        logic       isInterrupt;
        logic [4:0] code;                   // exception or interrupt code
    } trap_cause_t;

    typedef struct packed {
        logic        valid;
        logic [11:0] addr;                  // CSR number
        logic [31:0] data;
    } csr_write_t;

    typedef struct packed {
        logic        valid;
        trap_cause_t cause;
        vaddr_t      epc;                   // pc of the trapping instruction
    } trap_req_t;

    typedef struct packed {
        logic  valid;
        priv_t priv;                        // mret, sret or uret level
    } xret_req_t;

    typedef struct packed {
        priv_t      nextPriv;               // level the current trap lands in
        csr_xtvec_t mtvec;
        csr_xtvec_t stvec;
        csr_xtvec_t utvec;
        vaddr_t     mepc;
        vaddr_t     sepc;
        vaddr_t     uepc;
    } trap_csr_view_t;

    typedef struct packed {
        logic   flush;
        vaddr_t nextPc;                     // redirect target
    } redirect_t;

    typedef struct packed {
        logic ifStall;
        logic idStall;
        logic rrStall;
        logic bypassStall;
    } stall_t;

    localparam logic [11:0] CsrMtvec   = 12'h305;
    localparam logic [11:0] CsrStvec   = 12'h105;
    localparam logic [11:0] CsrUtvec   = 12'h005;
    localparam logic [11:0] CsrMepc    = 12'h341;
    localparam logic [11:0] CsrSepc    = 12'h141;
    localparam logic [11:0] CsrUepc    = 12'h041;
    localparam logic [11:0] CsrMedeleg = 12'h302;

endpackage

//--- tests/TrapRedirectTb.sv
// testbench for the trap and redirect slice, replays one record per cycle from the testdata file
`timescale 1ns/1ps

module TrapRedirectTb import TrapTypes::*; ();

    localparam int     ClkPeriod   = 100;              // ns
    localparam vaddr_t ResetVector = 32'h0000_1000;

    typedef struct packed {
        csr_write_t csrWrite;
        trap_req_t  trapReq;
        xret_req_t  xretReq;
        logic       flushReq;
        vaddr_t     flushTarget;
        logic       exStallReq;
        logic       expFlush;               // same cycle
        vaddr_t     expPc;                  // one cycle later
        priv_t      expPriv;                // one cycle later
    } record_t;

    logic       clk;
    logic       rstN;
    csr_write_t csrWrite;
    trap_req_t  trapReq;
    xret_req_t  xretReq;
    logic       flushReq;
    vaddr_t     flushTarget;
    logic       exStallReq;
    vaddr_t     pc;
    logic       flush;
    stall_t     stall;
    priv_t      curPriv;
    record_t    records[$];
    bit         loaded;                     // releases the watchdog

    TrapRedirectTop #(
        .ResetVector (ResetVector)
    ) u_TrapRedirectTop (
        .clk         (clk),
        .rstN        (rstN),
        .csrWrite    (csrWrite),
        .trapReq     (trapReq),
        .xretReq     (xretReq),
        .flushReq    (flushReq),
        .flushTarget (flushTarget),
        .exStallReq  (exStallReq),
        .pc          (pc),
        .flush       (flush),
        .stall       (stall),
        .curPriv     (curPriv)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compareAddr(input string name, input vaddr_t actual, input vaddr_t expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s expected %h got %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic comparePriv(input string name, input priv_t actual, input priv_t expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s expected %h got %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic compareFlush(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s expected %b got %b",
                               $time, name, expected, actual));
        end
    endtask

    task automatic compareStall(input string name, input stall_t actual, input stall_t expected);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s expected %b got %b",
                               $time, name, expected, actual));
        end
    endtask

    task automatic driveIdle();
        csrWrite    = '0;
        trapReq     = '0;
        xretReq     = '0;
        flushReq    = 1'b0;
        flushTarget = '0;
        exStallReq  = 1'b0;
    endtask

    task automatic driveRecord(input record_t r);
        csrWrite    = r.csrWrite;
        trapReq     = r.trapReq;
        xretReq     = r.xretReq;
        flushReq    = r.flushReq;
        flushTarget = r.flushTarget;
        exStallReq  = r.exStallReq;
    endtask

    task automatic loadRecords();
        int          fd;
        int          nFields;
        string       line;
        logic [31:0] cwValid, cwAddr, cwData;
        logic [31:0] trValid, trInt, trCode, trEpc;
        logic [31:0] xrValid, xrPriv, flReq, flTarget, exStall;
        logic [31:0] eFlush, ePc, ePriv;
        record_t     rec;
        fd = $fopen("tests/trap_testdata.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open tests/trap_testdata.txt");
        end
        else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin   // skip blanks and comments
                    nFields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                      cwValid, cwAddr, cwData, trValid, trInt, trCode, trEpc,
                                      xrValid, xrPriv, flReq, flTarget, exStall,
                                      eFlush, ePc, ePriv);
                    if (nFields != 15) begin
                        abortRun("malformed record in the testdata file");
                    end
                    rec.csrWrite.valid         = cwValid[0];
                    rec.csrWrite.addr          = cwAddr[11:0];
                    rec.csrWrite.data          = cwData;
                    rec.trapReq.valid          = trValid[0];
                    rec.trapReq.cause.isInterrupt = trInt[0];
                    rec.trapReq.cause.code     = trCode[4:0];
                    rec.trapReq.epc            = trEpc;
                    rec.xretReq.valid          = xrValid[0];
                    rec.xretReq.priv           = priv_t'(xrPriv[1:0]);
                    rec.flushReq               = flReq[0];
                    rec.flushTarget            = flTarget;
                    rec.exStallReq             = exStall[0];
                    rec.expFlush               = eFlush[0];
                    rec.expPc                  = ePc;
                    rec.expPriv                = priv_t'(ePriv[1:0]);
                    records.push_back(rec);
                end
            end
            $fclose(fd);
        end
    endtask

    // limit is the record count plus some slack for reset
    initial begin
        wait (loaded);
        #((records.size() + 10) * ClkPeriod);
        abortRun("timeout: the run did not finish in the expected number of cycles");
    end

    initial begin
        rstN = 1'b0;
        driveIdle();
        loadRecords();
        loaded = 1'b1;
        repeat (4) @(negedge clk);
        rstN = 1'b1;                        // release on a falling edge
        compareAddr("pc", pc, ResetVector);
        comparePriv("curPriv", curPriv, Priv_Machine);
        compareFlush("flush", flush, 1'b0);
        for (int i = 0; i < records.size(); i++) begin
            driveRecord(records[i]);
            #(ClkPeriod / 4);               // mid low phase, comb outputs settled
            compareFlush("flush", flush, records[i].expFlush);
            compareStall("stall", stall, stall_t'({4{records[i].exStallReq}}));
            @(negedge clk);
            compareAddr("pc", pc, records[i].expPc);
            comparePriv("curPriv", curPriv, records[i].expPriv);
        end
        driveIdle();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- tests/TrapRedirect_chk.sv
// assertion checker for the trap and redirect top level, attached to it by the bind below
`timescale 1ns/1ps

module TrapRedirect_chk import TrapTypes::*; (
    input logic      clk,
    input logic      rstN,
    input logic      flush,
    input redirect_t redirect,              // controller output inside the top
    input stall_t    stall,
    input logic      exStallReq,
    input vaddr_t    pc
);

    // all requests are low in reset so nothing may redirect
    quietInReset: assert property (@(posedge clk) !rstN |-> !flush)
        else $error("flush high while reset is active");

    flushLandsNextCycle: assert property (@(posedge clk) disable iff (!rstN)
        redirect.flush |=> pc == $past(redirect.nextPc))
        else $error("pc did not take the redirect target after a flush");

    stallHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
        (stall.ifStall && !flush) |=> $stable(pc))
        else $error("pc moved during a stall without flush");

    stallFollowsEx: assert property (@(posedge clk) stall == {4{exStallReq}})
        else $error("stall bits differ from exStallReq");

endmodule

bind TrapRedirectTop TrapRedirect_chk u_TrapRedirect_chk (
    .clk        (clk),
    .rstN       (rstN),
    .flush      (flush),
    .redirect   (redirect),
    .stall      (stall),
    .exStallReq (exStallReq),
    .pc         (pc)
);

//--- tests/trap_testdata.txt
# in: csrValid csrAddr csrData trapValid isInt code epc xretValid xretPriv flushReq flushTarget exStall
# out: flush pcNextCycle privNextCycle; all fields hex, one record per cycle
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 00001004 3
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 00001008 3
0 000 00000000 0 0 00 00000000 0 0 0 00000000 1 0 00001008 3
0 000 00000000 0 0 00 00000000 0 0 0 00000000 1 0 00001008 3
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 0000100c 3
0 000 00000000 0 0 00 00000000 0 0 1 00002000 0 1 00002000 3
0 000 00000000 0 0 00 00000000 0 0 1 00003000 1 1 00003000 3
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 00003004 3
1 305 00000400 0 0 00 00000000 0 0 0 00000000 0 0 00003008 3
0 000 00000000 1 0 02 00003008 0 0 0 00000000 0 1 00000400 3
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 00000404 3
0 000 00000000 0 0 00 00000000 1 3 0 00000000 0 1 00003008 0
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 0000300c 0
1 305 00000801 0 0 00 00000000 0 0 0 00000000 0 0 00003010 0
0 000 00000000 1 1 07 00003010 0 0 0 00000000 0 1 0000081c 3
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 00000820 3
0 000 00000000 1 0 02 00000820 0 0 0 00000000 0 1 00000800 3
0 000 00000000 0 0 00 00000000 1 3 0 00000000 0 1 00000820 0
1 302 00000100 0 0 00 00000000 0 0 0 00000000 0 0 00000824 0
1 105 00000600 0 0 00 00000000 0 0 0 00000000 0 0 00000828 0
0 000 00000000 1 0 08 00000828 0 0 0 00000000 0 1 00000600 1
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 00000604 1
0 000 00000000 0 0 00 00000000 1 1 0 00000000 0 1 00000828 0
0 000 00000000 1 0 02 00000828 0 0 0 00000000 0 1 00000800 3
0 000 00000000 1 0 08 00000800 0 0 0 00000000 0 1 00000800 3
0 000 00000000 1 0 03 00000800 0 0 1 00005000 0 1 00000800 3
0 000 00000000 0 0 00 00000000 0 0 0 00000000 0 0 00000804 3
1 341 00001234 1 0 02 00000804 0 0 0 00000000 0 1 00000800 3
0 000 00000000 0 0 00 00000000 1 3 0 00000000 0 1 00000804 0
